/* vlog.f */
+incdir+include
verilog/nic_pkg.sv
verilog/nic_ring_stage.sv
verilog/nic_read_timer.sv
verilog/nic_mem.sv
verilog/nic_ctrl.sv
verilog/ring_top.sv
dv/ring_tb.sv

/* dv/ring_golden.txt */
# Columns in hex: grp node we adr wdat exp_dat exp_err
# grp 1 lines run on their hosts at once, each host in a shuffled order
0 2 0 810044 00 00 0
0 3 0 8200a0 00 00 0
0 1 0 830001 00 00 0
# Write from node 1 into node 2, read back from node 3
0 1 1 820010 5a 00 0
0 3 0 820010 00 5a 0
# Nodes that address themselves
0 2 1 820020 c3 00 0
0 2 0 820020 00 c3 0
0 3 1 830021 7e 00 0
0 3 0 830021 00 7e 0
# Broadcast write, then the same offset on every node
0 1 1 8f0030 99 00 0
0 1 0 810030 00 99 0
0 2 0 820030 00 99 0
0 3 0 830030 00 99 0
# Absent node 7, then accesses with bit 23 clear
0 2 0 870005 00 ff 1
0 3 0 020010 00 ff 1
0 1 1 030010 11 ff 1
# Hosts 1 and 2 at once, all on node 3 at different offsets
1 1 1 830040 a1 00 0
1 1 1 830041 a2 00 0
1 1 0 830021 00 7e 0
1 1 0 830001 00 00 0
1 2 1 830050 b1 00 0
1 2 1 830051 b2 00 0
1 2 0 830030 00 99 0
1 2 0 830011 00 00 0
# Read back what the concurrent writes left behind
0 3 0 830040 00 a1 0
0 3 0 830041 00 a2 0
0 1 0 830050 00 b1 0
0 2 0 830051 00 b2 0

/* dv/ring_tb.sv */
// Ring NIC testbench with golden file transactions on the host ports, result checks and wait bounds
`timescale 1ns/1ps
`include "nic_defs.svh"

module ring_tb;
	import nic_pkg::*;

	localparam int NODES = `NIC_NODES;
	// Longest wait on any host handshake in cycles
	localparam int WAIT_MAX = 4 * `NIC_READ_TIMEOUT;
	// Idle cycles between lines that let a broadcast be purged
	localparam int SEQ_GAP = 8;

	// One line of the golden file
	typedef struct packed {
		logic                    grp;
		logic [`NIC_ID_W-1:0]    node;
		logic                    we;
		logic [`NIC_HOST_AW-1:0] adr;
		logic [`NIC_DAT_W-1:0]   dat;
		logic [`NIC_DAT_W-1:0]   exp_dat;
		logic                    exp_err;
	} xact_t;

	logic                  clk_i;
	logic                  rst_n_i;
	bus_req_t              host_req [NODES];
	logic [NODES-1:0]      host_ack;
	logic [NODES-1:0]      host_err;
	logic [`NIC_DAT_W-1:0] host_dat [NODES];

	xact_t xacts [$];
	// Per-host queues of a concurrent group
	xact_t pend [NODES][$];
	int    done_cnt;

	ring_top u_dut (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.host_req_i (host_req),
		.host_ack_o (host_ack),
		.host_err_o (host_err),
		.host_dat_o (host_dat)
	);

	always #10 clk_i = ~clk_i;

	// ==========================================================================
	// Checks and handshakes
	// ==========================================================================

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_val(input string name, input int n,
		input logic [`NIC_DAT_W-1:0] got, input logic [`NIC_DAT_W-1:0] exp_v);
		assert (got === exp_v)
		else
			stop_run($sformatf("error at %0t ns: %s[%0d] is %h, expected %h",
				$time, name, n, got, exp_v));
	endtask

	// Outputs are sampled on the falling edge away from the register updates
	task automatic wait_ack(input int n, input logic level);
		int cnt;
		cnt = 0;
		while (host_ack[n] !== level && cnt < WAIT_MAX)
		begin
			@(negedge clk_i);
			cnt++;
		end
		assert (host_ack[n] === level)
		else
			stop_run($sformatf("host %0d handshake did not complete within %0d cycles",
				n + 1, WAIT_MAX));
	endtask

	// A full host cycle strobes, waits for the ack and checks, then drops the strobe
	task automatic do_xact(input xact_t t);
		int       n;
		bus_req_t req;
		n = t.node - 1;
		req = '{cyc: 1'b1, stb: 1'b1, we: t.we, adr: t.adr, dat: t.dat};
		@(posedge clk_i);
		host_req[n] <= req;
		@(negedge clk_i);
		wait_ack(n, 1'b1);
		check_val("host_err_o", n, 8'(host_err[n]), 8'(t.exp_err));
		// Posted writes carry no data back
		if (!t.we || t.exp_err)
			check_val("host_dat_o", n, host_dat[n], t.exp_dat);
		@(posedge clk_i);
		host_req[n] <= '0;
		@(negedge clk_i);
		wait_ack(n, 1'b0);
		done_cnt++;
	endtask

	// ==========================================================================
	// Golden file and concurrent groups
	// ==========================================================================

	task automatic load_golden();
		int    fd;
		int    cnt;
		int    grp;
		int    node;
		int    we;
		int    adr;
		int    dat;
		int    exp_dat;
		int    exp_err;
		string line;
		xact_t t;
		fd = $fopen("dv/ring_golden.txt", "r");
		if (fd == 0)
			stop_run("cannot open the golden file dv/ring_golden.txt");
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			// Lines starting with # are comments and short lines are skipped
			if (line.len() > 0 && line[0] != "#")
			begin
				cnt = $sscanf(line, "%h %h %h %h %h %h %h",
					grp, node, we, adr, dat, exp_dat, exp_err);
				if (cnt == 7)
				begin
					t = '{grp: grp[0], node: node[`NIC_ID_W-1:0], we: we[0],
						adr: adr[`NIC_HOST_AW-1:0], dat: dat[`NIC_DAT_W-1:0],
						exp_dat: exp_dat[`NIC_DAT_W-1:0], exp_err: exp_err[0]};
					xacts.push_back(t);
				end
			end
		end
		$fclose(fd);
	endtask

	// Fisher-Yates shuffle of one host's queue
	task automatic shuffle_node(input int k);
		int    j;
		xact_t tmp;
		for (int i = pend[k].size() - 1; i > 0; i--)
		begin
			j = $urandom % (i + 1);
			tmp = pend[k][i];
			pend[k][i] = pend[k][j];
			pend[k][j] = tmp;
		end
	endtask

	task automatic run_node(input int k);
		xact_t t;
		while (pend[k].size() > 0)
		begin
			t = pend[k].pop_front();
			do_xact(t);
		end
	endtask

	// Every host works through its own queue while the others run
	task automatic run_group();
		for (int k = 0; k < NODES; k++)
			shuffle_node(k);
		fork
			run_node(0);
			run_node(1);
			run_node(2);
		join
	endtask

	// ==========================================================================
	// Main sequence
	// ==========================================================================

	initial
	begin
		int i;
		void'($urandom(53));
		clk_i = 1'b0;
		rst_n_i = 1'b0;
		for (int k = 0; k < NODES; k++)
			host_req[k] = '0;
		done_cnt = 0;
		load_golden();
		assert (xacts.size() > 0)
		else
			stop_run("the golden file holds no transactions");

		repeat (5) @(posedge clk_i);
		rst_n_i <= 1'b1;

		// Nothing is acked or flagged right after reset
		@(negedge clk_i);
		for (int k = 0; k < NODES; k++)
		begin
			check_val("host_ack_o", k, 8'(host_ack[k]), 8'h00);
			check_val("host_err_o", k, 8'(host_err[k]), 8'h00);
		end

		i = 0;
		while (i < xacts.size())
		begin
			if (xacts[i].grp)
			begin
				// Collect the whole run of concurrent lines before starting it
				while (i < xacts.size() && xacts[i].grp)
				begin
					pend[xacts[i].node - 1].push_back(xacts[i]);
					i++;
				end
				run_group();
			end
			else
			begin
				do_xact(xacts[i]);
				i++;
			end
			repeat (SEQ_GAP) @(posedge clk_i);
		end

		if (done_cnt == xacts.size())
		begin
			$display("TEST PASSED");
			$finish;
		end
		else
		begin
			$display("TEST FAILED");
			$fatal(1, "%0d of %0d transactions completed", done_cnt, xacts.size());
		end
	end

endmodule

/* verilog/ring_top.sv */
// Top level ring of NIC nodes with every host port brought out
`timescale 1ns/1ps
`include "nic_defs.svh"

module ring_top (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  nic_pkg::bus_req_t     host_req_i [`NIC_NODES],
	output logic [`NIC_NODES-1:0] host_ack_o,
	output logic [`NIC_NODES-1:0] host_err_o,
	output logic [`NIC_DAT_W-1:0] host_dat_o [`NIC_NODES]
);
	import nic_pkg::*;

	localparam int NODES = `NIC_NODES;
	localparam int ID_W = `NIC_ID_W;

	// Output slot of each stage, read by the stage of the next node
	packet_t ring [NODES];

	generate
		for (genvar k = 0; k < NODES; k++)
		begin : g_node
			// The first stage is fed by the last one to close the ring
			localparam int PREV = (k == 0) ? NODES - 1 : k - 1;
			// Id 0 means an empty slot, so nodes count from 1
			localparam logic [ID_W-1:0] NODE_ID = ID_W'(k + 1);

			packet_t               rx_pkt;
			packet_t               ins_pkt;
			logic                  consume;
			logic                  insert;
			logic                  inserted;
			bus_req_t              mem_req;
			logic                  mem_ack;
			logic [`NIC_DAT_W-1:0] mem_dat;
			logic                  tmr_start;
			logic                  tmr_clear;
			logic                  tmr_expired;

			nic_ring_stage u_stage (
				.clk_i      (clk_i),
				.rst_n_i    (rst_n_i),
				.pkt_i      (ring[PREV]),
				.pkt_o      (ring[k]),
				.rx_pkt_o   (rx_pkt),
				.consume_i  (consume),
				.insert_i   (insert),
				.ins_pkt_i  (ins_pkt),
				.inserted_o (inserted)
			);

			nic_ctrl u_ctrl (
				.clk_i         (clk_i),
				.rst_n_i       (rst_n_i),
				.node_id_i     (NODE_ID),
				.host_req_i    (host_req_i[k]),
				.host_ack_o    (host_ack_o[k]),
				.host_err_o    (host_err_o[k]),
				.host_dat_o    (host_dat_o[k]),
				.rx_pkt_i      (rx_pkt),
				.consume_o     (consume),
				.insert_o      (insert),
				.ins_pkt_o     (ins_pkt),
				.inserted_i    (inserted),
				.mem_req_o     (mem_req),
				.mem_ack_i     (mem_ack),
				.mem_dat_i     (mem_dat),
				.tmr_start_o   (tmr_start),
				.tmr_clear_o   (tmr_clear),
				.tmr_expired_i (tmr_expired)
			);

			nic_read_timer u_timer (
				.clk_i     (clk_i),
				.rst_n_i   (rst_n_i),
				.start_i   (tmr_start),
				.clear_i   (tmr_clear),
				.expired_o (tmr_expired)
			);

			nic_mem u_mem (
				.clk_i   (clk_i),
				.rst_n_i (rst_n_i),
				.req_i   (mem_req),
				.ack_o   (mem_ack),
				.dat_o   (mem_dat)
			);
		end
	endgenerate

endmodule

/* verilog/nic_ctrl.sv */
// Node controller FSM for packet decode, host service, memory cycles and transmit requests
`timescale 1ns/1ps
`include "nic_defs.svh"

module nic_ctrl (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic [`NIC_ID_W-1:0]  node_id_i,
	input  nic_pkg::bus_req_t     host_req_i,
	output logic                  host_ack_o,
	output logic                  host_err_o,
	output logic [`NIC_DAT_W-1:0] host_dat_o,
	input  nic_pkg::packet_t      rx_pkt_i,
	output logic                  consume_o,
	output logic                  insert_o,
	output nic_pkg::packet_t      ins_pkt_o,
	input  logic                  inserted_i,
	output nic_pkg::bus_req_t     mem_req_o,
	input  logic                  mem_ack_i,
	input  logic [`NIC_DAT_W-1:0] mem_dat_i,
	output logic                  tmr_start_o,
	output logic                  tmr_clear_o,
	input  logic                  tmr_expired_i
);
	import nic_pkg::*;

	localparam int PAD_W = `NIC_HOST_AW - `NIC_PKT_AW;

	ctrl_state_e          state;
	ctrl_state_e          back_state;
	packet_t              rx_q;
	packet_t              tx_q;
	logic [`NIC_ID_W-1:0] rd_src;
	logic                 rd_pend;
	logic                 ack_got;
	logic                 tmo_got;
	logic                 rx_mine;
	logic                 rx_bcast;
	logic                 rx_req;
	logic                 take_req;
	logic                 take_ack;
	logic                 host_go;
	logic                 host_new;
	logic                 host_remote;

	// ==========================================================================
	// Packet decode
	// ==========================================================================

	assign rx_mine = (rx_pkt_i.did == node_id_i);
	assign rx_bcast = (rx_pkt_i.did == `NIC_BCAST_ID);

	// Writes are taken when addressed or broadcast, reads only when addressed
	assign rx_req = (rx_pkt_i.ptype == PT_WRITE && (rx_mine || rx_bcast)) ||
		(rx_pkt_i.ptype == PT_READ && rx_mine);

	// Requests are served while idle, waiting for an answer or holding the host ack
	// In every other state they pass on untouched
	assign take_req = rx_req && (state == IDLE || state == WAIT_ACK || state == HOST_DONE);

	// The answer to our read may turn up in any state, it is latched until WAIT_ACK
	assign take_ack = rd_pend && !ack_got && rx_pkt_i.ptype == PT_ACK && rx_mine &&
		rx_pkt_i.sid == rd_src;

	// Broadcasts stay on the ring until the age limit purges them
	assign consume_o = (take_req && !rx_bcast) || take_ack;

	// ==========================================================================
	// Transmit and timer control
	// ==========================================================================

	assign insert_o = (state == SEND_REQ || state == SEND_ACK);
	assign ins_pkt_o = tx_q;
	assign tmr_start_o = (state == SEND_REQ) && inserted_i && (tx_q.ptype == PT_READ);
	assign tmr_clear_o = take_ack;

	assign host_go = host_req_i.cyc && host_req_i.stb;
	assign host_new = (state == IDLE) && !take_req && host_go && !host_ack_o;
	assign host_remote = host_req_i.adr[`NIC_HOST_AW-1];

	// After serving the ring, go back to waiting if a read is outstanding
	assign back_state = rd_pend ? WAIT_ACK : IDLE;

	// Packet registers
	always_ff @(posedge clk_i)
	begin
		if (take_req)
			rx_q <= rx_pkt_i;
		if (host_new && host_remote)
		begin
			tx_q <= '{did: host_req_i.adr[16 +: `NIC_ID_W], sid: node_id_i, age: '0,
				ptype: host_req_i.we ? PT_WRITE : PT_READ,
				adr: host_req_i.adr[`NIC_PKT_AW-1:0], dat: host_req_i.dat};
			rd_src <= host_req_i.adr[16 +: `NIC_ID_W];
		end
		else if (state == MEM_READ && mem_ack_i)
			tx_q <= '{did: rx_q.sid, sid: node_id_i, age: '0, ptype: PT_ACK,
				adr: rx_q.adr, dat: mem_dat_i};
	end

	// ==========================================================================
	// State machine
	// ==========================================================================

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state <= IDLE;
			host_ack_o <= 1'b0;
			host_err_o <= 1'b0;
			host_dat_o <= '0;
			rd_pend <= 1'b0;
			ack_got <= 1'b0;
			tmo_got <= 1'b0;
			mem_req_o <= '0;
		end
		else
		begin
			// The host ack ends when the host drops its strobe in any state
			if (host_ack_o && !host_go)
			begin
				host_ack_o <= 1'b0;
				host_err_o <= 1'b0;
			end
			if (take_ack)
			begin
				ack_got <= 1'b1;
				host_dat_o <= rx_pkt_i.dat;
			end
			if (rd_pend && tmr_expired_i)
				tmo_got <= 1'b1;

			if (take_req)
			begin
				// Start the memory cycle for the packet on the ring now
				mem_req_o <= '{cyc: 1'b1, stb: 1'b1, we: rx_pkt_i.ptype == PT_WRITE,
					adr: {{PAD_W{1'b0}}, rx_pkt_i.adr}, dat: rx_pkt_i.dat};
				state <= (rx_pkt_i.ptype == PT_WRITE) ? MEM_WRITE : MEM_READ;
			end
			else
			begin
				case (state)
				IDLE:
					if (host_new)
					begin
						if (host_remote)
							state <= SEND_REQ;
						else
						begin
							// Local addresses are not served, answer with an error
							host_ack_o <= 1'b1;
							host_err_o <= 1'b1;
							host_dat_o <= `NIC_FILL_DATA;
							state <= HOST_DONE;
						end
					end
				SEND_REQ:
					if (inserted_i)
					begin
						if (tx_q.ptype == PT_WRITE)
						begin
							// Posted write
							host_ack_o <= 1'b1;
							host_err_o <= 1'b0;
							state <= HOST_DONE;
						end
						else
						begin
							rd_pend <= 1'b1;
							state <= WAIT_ACK;
						end
					end
				WAIT_ACK:
					if (ack_got || tmo_got)
					begin
						// An answer beats a timeout that fired in the same window
						host_ack_o <= 1'b1;
						host_err_o <= !ack_got;
						if (!ack_got)
							host_dat_o <= `NIC_FILL_DATA;
						rd_pend <= 1'b0;
						ack_got <= 1'b0;
						tmo_got <= 1'b0;
						state <= HOST_DONE;
					end
				MEM_READ:
					if (mem_ack_i)
					begin
						mem_req_o.cyc <= 1'b0;
						mem_req_o.stb <= 1'b0;
						state <= SEND_ACK;
					end
				MEM_WRITE:
					if (mem_ack_i)
					begin
						mem_req_o.cyc <= 1'b0;
						mem_req_o.stb <= 1'b0;
						state <= back_state;
					end
				SEND_ACK:
					if (inserted_i)
						state <= back_state;
				HOST_DONE:
					if (!host_go)
						state <= IDLE;
				default:
					state <= IDLE;
				endcase
			end
		end
	end

	// Every memory strobe comes with cyc and is acked by the memory one cycle later
	a_mem_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$rose(mem_req_o.stb) |-> mem_req_o.cyc ##1 mem_ack_i)
		else $error("memory strobe without cyc or without ack");

endmodule

/* verilog/nic_mem.sv */
// Local byte memory of a node as a cycle/strobe bus slave
`timescale 1ns/1ps
`include "nic_defs.svh"

module nic_mem (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  nic_pkg::bus_req_t     req_i,
	output logic                  ack_o,
	output logic [`NIC_DAT_W-1:0] dat_o
);
	localparam int AW = $clog2(`NIC_MEM_DEPTH);

	logic [`NIC_DAT_W-1:0] mem [`NIC_MEM_DEPTH];
	logic                  hit;

	// Serve a strobe once, the ack cycle blocks a second access
	assign hit = req_i.cyc && req_i.stb && !ack_o;

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			ack_o <= 1'b0;
			dat_o <= '0;
			// Unwritten bytes read back as zero
			for (int i = 0; i < `NIC_MEM_DEPTH; i++)
				mem[i] <= '0;
		end
		else
		begin
			ack_o <= hit;
			if (hit)
			begin
				if (req_i.we)
					mem[req_i.adr[AW-1:0]] <= req_i.dat;
				dat_o <= mem[req_i.adr[AW-1:0]];
			end
		end
	end

	// Every ack answers a strobe that the master still holds while it is acked
	a_ack_after_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		ack_o |-> $past(req_i.cyc && req_i.stb) && req_i.cyc && req_i.stb)
		else $error("memory ack without a held strobe");

endmodule

/* verilog/nic_read_timer.sv */
// Down-counter that bounds the wait of a host read for its answer
`timescale 1ns/1ps
`include "nic_defs.svh"

module nic_read_timer (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic start_i,
	input  logic clear_i,
	output logic expired_o
);
	localparam int CNT_W = $clog2(`NIC_READ_TIMEOUT);

	logic [CNT_W-1:0] cnt;
	logic             running;

	// Zero is reached exactly the timeout after the start cycle
	assign expired_o = running && (cnt == '0);

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			running <= 1'b0;
			cnt <= '0;
		end
		else if (start_i)
		begin
			running <= 1'b1;
			cnt <= CNT_W'(`NIC_READ_TIMEOUT - 1);
		end
		// The expiry pulse also stops the timer, so it fires once
		else if (clear_i || expired_o)
			running <= 1'b0;
		else if (running)
			cnt <= cnt - 1'b1;
	end

	// The controller holds one read outstanding at a time
	a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		start_i |-> !running)
		else $error("read timer restarted while running");

endmodule

/* verilog/nic_ring_stage.sv */
// Ring slot register with packet aging, purge, consume and insert
`timescale 1ns/1ps
`include "nic_defs.svh"

module nic_ring_stage (
	input  logic             clk_i,
	input  logic             rst_n_i,
	input  nic_pkg::packet_t pkt_i,
	output nic_pkg::packet_t pkt_o,
	output nic_pkg::packet_t rx_pkt_o,
	input  logic             consume_i,
	input  logic             insert_i,
	input  nic_pkg::packet_t ins_pkt_i,
	output logic             inserted_o
);
	import nic_pkg::*;

	// A packet arriving with this age would reach the limit in this hop
	localparam int AGE_LAST = `NIC_MAX_AGE - 1;

	packet_t aged;
	logic    slot_free;

	// The controller looks at the packet before it is aged
	assign rx_pkt_o = pkt_i;

	// Age the passing packet and drop it when consumed or too old
	always_comb
	begin
		aged = pkt_i;
		aged.age = pkt_i.age + 1'b1;
		if (pkt_i.did == '0 || consume_i || pkt_i.age >= AGE_LAST)
			aged = '0;
	end

	assign slot_free = (aged.did == '0);

	// The grant is combinational so the controller drops insert_i in the next cycle
	assign inserted_o = insert_i && slot_free;

	// One register per hop
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			pkt_o <= '0;
		else if (inserted_o)
			pkt_o <= ins_pkt_i;
		else
			pkt_o <= aged;
	end

	// A live packet that is neither consumed nor purged leaves intact and one hop older
	a_no_overwrite: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(pkt_i.did != '0 && !consume_i && pkt_i.age < AGE_LAST) |=>
			({pkt_o.did, pkt_o.sid, pkt_o.ptype, pkt_o.adr, pkt_o.dat} ==
				$past({pkt_i.did, pkt_i.sid, pkt_i.ptype, pkt_i.adr, pkt_i.dat}) &&
			pkt_o.age == $past(pkt_i.age) + 1'b1))
		else $error("ring stage overwrote an occupied slot");

endmodule

/* verilog/nic_pkg.sv */
// Ring NIC types: packet type enum, packet struct, bus request struct, controller state enum
`include "nic_defs.svh"

package nic_pkg;

	// Packet kinds carried in a ring slot
	typedef enum logic [1:0] {
		PT_NULL,
		PT_READ,
		PT_WRITE,
		PT_ACK
	} pkt_type_e;

	// One ring slot, 38 bits wide
	// A did of zero means the slot is empty
	typedef struct packed {
		logic [`NIC_ID_W-1:0]   did;
		logic [`NIC_ID_W-1:0]   sid;
		logic [`NIC_AGE_W-1:0]  age;
		pkt_type_e              ptype;
		logic [`NIC_PKT_AW-1:0] adr;
		logic [`NIC_DAT_W-1:0]  dat;
	} packet_t;

	// Cycle/strobe bus request, used on both the host and the memory side
	// The memory side only fills the low 16 address bits
	typedef struct packed {
		logic                    cyc;
		logic                    stb;
		logic                    we;
		logic [`NIC_HOST_AW-1:0] adr;
		logic [`NIC_DAT_W-1:0]   dat;
	} bus_req_t;

	// Node controller states
	typedef enum logic [2:0] {
		IDLE,
		MEM_READ,
		MEM_WRITE,
		SEND_ACK,
		SEND_REQ,
		WAIT_ACK,
		HOST_DONE
	} ctrl_state_e;

endpackage

/* include/nic_defs.svh */
// Ring NIC parameters: node count, field widths, age limit, read timeout and fill data
`ifndef NIC_DEFS_SVH
`define NIC_DEFS_SVH

// Number of nodes on the ring
`define NIC_NODES 3

// Node id width, id 0 marks an empty slot
`define NIC_ID_W 4

// Destination id that addresses every node
`define NIC_BCAST_ID 4'd15

// Field widths of packets and bus requests
`define NIC_AGE_W 4
`define NIC_HOST_AW 24
`define NIC_PKT_AW 16
`define NIC_DAT_W 8

// Hop count at which a ring stage purges a packet
`define NIC_MAX_AGE (2 * `NIC_NODES)

// Cycles a host read may wait for its answer, and the data it gets on timeout
`define NIC_READ_TIMEOUT 64
`define NIC_FILL_DATA 8'hFF

// Bytes of local memory per node
`define NIC_MEM_DEPTH 256

`endif
